//--- compile.f
+incdir+include
hw/eth_pkg.sv
hw/eth_reg_if.sv
hw/eth_tx_serializer.sv
hw/eth_rx_packer.sv
hw/udma_ethernet.sv
testbench/tb_udma_ethernet.sv

//--- hw/eth_pkg.sv
// shared widths, types and register map of the uDMA ethernet adapter
// uDMA transfers are always full 32-bit words, streams are byte wide
// needs include/ on the include path for the register map
package eth_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;   // must stay a power of two
    localparam int CFG_ADDR_W     = 5;
    localparam int FRAME_LEN_W    = 16;
    localparam int FRAME_CNT_W    = 8;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BYTE_W-1:0]      eth_byte_t;
    typedef logic [FRAME_LEN_W-1:0] frame_len_t;
    typedef logic [CFG_ADDR_W-1:0]  cfg_addr_t;

    // control fields, fanned out to both channels
    typedef struct packed {
        logic       en_tx;
        logic       en_rx;
        logic       rx_irq_en;
        frame_len_t tx_len;
    } eth_ctrl_t;

    // rx status, frame_len qualified by frame_done
    typedef struct packed {
        logic       frame_done;
        frame_len_t frame_len;
    } rx_stat_t;

    typedef enum logic {IDLE, SEND} tx_state_e;

    typedef enum logic {COLLECT, HOLD} rx_state_e;

    `include "eth_reg_map.svh"

endpackage

//--- hw/eth_reg_if.sv
// cfg bus register file
// cfg_ready_o is tied high, reads return one cycle after the request
// and cfg_data_o keeps the last read value until the next read
// rx length and frame count are only updated on the rx frame_done pulse
module eth_reg_if (
    input  logic               sys_clk_i,
    input  logic               rst_i,
    input  eth_pkg::cfg_addr_t cfg_addr_i,
    input  eth_pkg::word_t     cfg_data_i,
    input  logic               cfg_valid_i,
    input  logic               cfg_rwn_i,
    output logic               cfg_ready_o,
    output eth_pkg::word_t     cfg_data_o,
    input  logic               tx_busy_i,
    input  eth_pkg::rx_stat_t  rx_stat_i,
    output eth_pkg::eth_ctrl_t ctrl_o
);
    import eth_pkg::*;

    eth_ctrl_t               ctrl_q;
    frame_len_t              rx_len_q;
    logic [FRAME_CNT_W-1:0]  frame_cnt_q;
    word_t                   rd_data;
    logic                    cfg_wr;
    logic                    cfg_rd;

    assign cfg_ready_o = 1'b1;  // never stalls
    assign cfg_wr      = cfg_valid_i && !cfg_rwn_i;
    assign cfg_rd      = cfg_valid_i && cfg_rwn_i;
    assign ctrl_o      = ctrl_q;

    ////////////////////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr_i)
                REG_CTRL: begin
                    ctrl_q.en_tx     <= cfg_data_i[CTRL_EN_TX];
                    ctrl_q.en_rx     <= cfg_data_i[CTRL_EN_RX];
                    ctrl_q.rx_irq_en <= cfg_data_i[CTRL_RX_IRQ_EN];
                end
                REG_TX_LEN: ctrl_q.tx_len <= cfg_data_i[FRAME_LEN_W-1:0];
                default: ;  // read only or unmapped
            endcase
        end
    end

    // rx bookkeeping
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            rx_len_q    <= '0;
            frame_cnt_q <= '0;
        end else if (rx_stat_i.frame_done) begin
            rx_len_q    <= rx_stat_i.frame_len;
            frame_cnt_q <= frame_cnt_q + 1'b1;  // wraps at 256
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reads
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        case (cfg_addr_i)
            REG_CTRL: begin
                rd_data[CTRL_EN_TX]     = ctrl_q.en_tx;
                rd_data[CTRL_EN_RX]     = ctrl_q.en_rx;
                rd_data[CTRL_RX_IRQ_EN] = ctrl_q.rx_irq_en;
            end
            REG_TX_LEN: rd_data[FRAME_LEN_W-1:0] = ctrl_q.tx_len;
            REG_STATUS: begin
                rd_data[FRAME_CNT_W-1:0] = frame_cnt_q;
                rd_data[STAT_TX_BUSY]    = tx_busy_i;
            end
            REG_RX_LEN: rd_data[FRAME_LEN_W-1:0] = rx_len_q;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            cfg_data_o <= '0;
        end else if (cfg_rd) begin
            cfg_data_o <= rd_data;
        end
    end

    // read data only moves right after a read request
    a_rdata_hold: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        !$past(cfg_rd) |-> $stable(cfg_data_o));

endmodule

//--- hw/eth_rx_packer.sv
// byte stream to uDMA rx words, first byte lands in bits 7:0
// a last byte closes the word early, unused upper bytes read as zero
// frame_done and the rx event follow the transfer of the frame's final word
// no bytes are taken while en_rx is clear
module eth_rx_packer (
    input  logic               sys_clk_i,
    input  logic               rst_i,
    input  eth_pkg::eth_ctrl_t ctrl_i,
    input  eth_pkg::eth_byte_t eth_rx_data_i,
    input  logic               eth_rx_valid_i,
    input  logic               eth_rx_last_i,
    output logic               eth_rx_ready_o,
    output eth_pkg::word_t     data_rx_o,
    output logic               data_rx_valid_o,
    input  logic               data_rx_ready_i,
    output eth_pkg::rx_stat_t  rx_stat_o,
    output logic               eth_rx_event_o
);
    import eth_pkg::*;

    rx_state_e                          state_q;
    word_t                              word_q;
    logic [$clog2(BYTES_PER_WORD)-1:0]  byte_idx_q;
    frame_len_t                         len_cnt_q;    // running byte count
    frame_len_t                         frame_len_q;  // reported with frame_done
    logic                               last_word_q;  // held word ends the frame
    logic                               done_q;
    logic                               event_q;
    logic                               byte_acc;
    logic                               word_acc;

    assign eth_rx_ready_o  = (state_q == COLLECT) && ctrl_i.en_rx;
    assign data_rx_valid_o = (state_q == HOLD);
    assign data_rx_o       = word_q;
    assign byte_acc        = eth_rx_valid_i && eth_rx_ready_o;
    assign word_acc        = data_rx_valid_o && data_rx_ready_i;

    assign rx_stat_o      = '{frame_done: done_q, frame_len: frame_len_q};
    assign eth_rx_event_o = event_q;

    ////////////////////////////////////////////////////////////////////////////
    // FSM and counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            state_q     <= COLLECT;
            byte_idx_q  <= '0;
            len_cnt_q   <= '0;
            frame_len_q <= '0;
            last_word_q <= 1'b0;
            done_q      <= 1'b0;
            event_q     <= 1'b0;
        end else begin
            done_q  <= 1'b0;    // single cycle pulses
            event_q <= 1'b0;
            case (state_q)
                COLLECT: begin
                    if (byte_acc) begin
                        len_cnt_q <= len_cnt_q + 1'b1;
                        if (eth_rx_last_i || (&byte_idx_q)) begin
                            state_q     <= HOLD;
                            byte_idx_q  <= '0;
                            last_word_q <= eth_rx_last_i;
                        end else begin
                            byte_idx_q <= byte_idx_q + 1'b1;
                        end
                    end
                end
                HOLD: begin
                    if (word_acc) begin
                        state_q <= COLLECT;
                        if (last_word_q) begin
                            done_q      <= 1'b1;
                            event_q     <= ctrl_i.rx_irq_en;
                            frame_len_q <= len_cnt_q;
                            len_cnt_q   <= '0;
                        end
                    end
                end
                default: state_q <= COLLECT;
            endcase
        end
    end

    // first byte of a word also clears the bytes above it
    always_ff @(posedge sys_clk_i) begin
        if (byte_acc) begin
            if (byte_idx_q == '0) begin
                word_q <= word_t'(eth_rx_data_i);
            end else begin
                word_q[byte_idx_q*BYTE_W +: BYTE_W] <= eth_rx_data_i;
            end
        end
    end

    a_rx_word_hold: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        data_rx_valid_o && !data_rx_ready_i |=> data_rx_valid_o && $stable(data_rx_o));

    a_rx_event_pulse: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_rx_event_o |=> !eth_rx_event_o);

endmodule

//--- hw/eth_tx_serializer.sv
// uDMA tx words to byte stream, byte 0 of each word goes out first
// frame length is latched from ctrl when the first word of a frame is taken,
// so tx_len and en_tx changes only apply to the next frame
// bytes of the final word past tx_len are dropped
module eth_tx_serializer (
    input  logic               sys_clk_i,
    input  logic               rst_i,
    input  eth_pkg::eth_ctrl_t ctrl_i,
    input  eth_pkg::word_t     data_tx_i,
    input  logic               data_tx_valid_i,
    output logic               data_tx_ready_o,
    output eth_pkg::eth_byte_t eth_tx_data_o,
    output logic               eth_tx_valid_o,
    output logic               eth_tx_last_o,
    input  logic               eth_tx_ready_i,
    output logic               tx_busy_o
);
    import eth_pkg::*;

    tx_state_e                          state_q;
    word_t                              word_q;
    logic [$clog2(BYTES_PER_WORD)-1:0]  byte_idx_q;
    frame_len_t                         len_q;
    frame_len_t                         byte_cnt_q;  // bytes sent in this frame
    logic                               busy_q;      // also marks "inside a frame"
    logic                               word_acc;
    logic                               byte_acc;
    logic                               frame_end;

    // inside a frame keep pulling words, otherwise wait for a valid setup
    assign data_tx_ready_o = (state_q == IDLE) &&
                             (busy_q || (ctrl_i.en_tx && ctrl_i.tx_len != '0));
    assign word_acc  = data_tx_valid_i && data_tx_ready_o;
    assign byte_acc  = eth_tx_valid_o && eth_tx_ready_i;
    assign frame_end = (byte_cnt_q == len_q - 1'b1);

    assign eth_tx_valid_o = (state_q == SEND);
    assign eth_tx_data_o  = word_q[byte_idx_q*BYTE_W +: BYTE_W];
    assign eth_tx_last_o  = eth_tx_valid_o && frame_end;
    assign tx_busy_o      = busy_q;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            busy_q     <= 1'b0;
            byte_idx_q <= '0;
            byte_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (word_acc) begin
                        state_q    <= SEND;
                        busy_q     <= 1'b1;
                        byte_idx_q <= '0;
                        if (!busy_q) byte_cnt_q <= '0;  // new frame
                    end
                end
                SEND: begin
                    if (byte_acc) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (frame_end) begin
                            state_q <= IDLE;
                            busy_q  <= 1'b0;
                        end else if (&byte_idx_q) begin
                            state_q <= IDLE;   // word used up, fetch next
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (word_acc) word_q <= data_tx_i;
        if (word_acc && !busy_q) len_q <= ctrl_i.tx_len;
    end

    a_tx_hold: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_tx_valid_o && !eth_tx_ready_i |=>
        eth_tx_valid_o && $stable(eth_tx_data_o) && $stable(eth_tx_last_o));

    a_tx_exclusive: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        !(data_tx_ready_o && eth_tx_valid_o));

endmodule

//--- hw/udma_ethernet.sv
// uDMA ethernet frame adapter, single clock, synchronous active high reset
// byte streams replace the PHY side, no MAC or FCS handling here
// uDMA channel setup (addresses, sizes) is left to the uDMA core
module udma_ethernet (
    input  logic               sys_clk_i,
    input  logic               rst_i,

    // cfg bus
    input  eth_pkg::word_t     cfg_data_i,
    input  eth_pkg::cfg_addr_t cfg_addr_i,
    input  logic               cfg_valid_i,
    input  logic               cfg_rwn_i,
    output logic               cfg_ready_o,
    output eth_pkg::word_t     cfg_data_o,

    // uDMA channels
    input  eth_pkg::word_t     data_tx_i,
    input  logic               data_tx_valid_i,
    output logic               data_tx_ready_o,
    output eth_pkg::word_t     data_rx_o,
    output logic               data_rx_valid_o,
    input  logic               data_rx_ready_i,

    // byte streams
    output eth_pkg::eth_byte_t eth_tx_data_o,
    output logic               eth_tx_valid_o,
    output logic               eth_tx_last_o,
    input  logic               eth_tx_ready_i,
    input  eth_pkg::eth_byte_t eth_rx_data_i,
    input  logic               eth_rx_valid_i,
    input  logic               eth_rx_last_i,
    output logic               eth_rx_ready_o,

    output logic               eth_rx_event_o
);
    import eth_pkg::*;

    eth_ctrl_t ctrl;
    rx_stat_t  rx_stat;
    logic      tx_busy;

    eth_reg_if u_reg_if (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_i       ( rst_i       ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_data_i  ( cfg_data_i  ),
        .cfg_valid_i ( cfg_valid_i ),
        .cfg_rwn_i   ( cfg_rwn_i   ),
        .cfg_ready_o ( cfg_ready_o ),
        .cfg_data_o  ( cfg_data_o  ),
        .tx_busy_i   ( tx_busy     ),
        .rx_stat_i   ( rx_stat     ),
        .ctrl_o      ( ctrl        )
    );

    ////////////////////////////////////////////////////////////////////////////
    // tx side
    ////////////////////////////////////////////////////////////////////////////
    eth_tx_serializer u_tx_ser (
        .sys_clk_i       ( sys_clk_i       ),
        .rst_i           ( rst_i           ),
        .ctrl_i          ( ctrl            ),
        .data_tx_i       ( data_tx_i       ),
        .data_tx_valid_i ( data_tx_valid_i ),
        .data_tx_ready_o ( data_tx_ready_o ),
        .eth_tx_data_o   ( eth_tx_data_o   ),
        .eth_tx_valid_o  ( eth_tx_valid_o  ),
        .eth_tx_last_o   ( eth_tx_last_o   ),
        .eth_tx_ready_i  ( eth_tx_ready_i  ),
        .tx_busy_o       ( tx_busy         )
    );

    ////////////////////////////////////////////////////////////////////////////
    // rx side
    ////////////////////////////////////////////////////////////////////////////
    eth_rx_packer u_rx_pack (
        .sys_clk_i       ( sys_clk_i       ),
        .rst_i           ( rst_i           ),
        .ctrl_i          ( ctrl            ),
        .eth_rx_data_i   ( eth_rx_data_i   ),
        .eth_rx_valid_i  ( eth_rx_valid_i  ),
        .eth_rx_last_i   ( eth_rx_last_i   ),
        .eth_rx_ready_o  ( eth_rx_ready_o  ),
        .data_rx_o       ( data_rx_o       ),
        .data_rx_valid_o ( data_rx_valid_o ),
        .data_rx_ready_i ( data_rx_ready_i ),
        .rx_stat_o       ( rx_stat         ),
        .eth_rx_event_o  ( eth_rx_event_o  )
    );

endmodule

//--- include/eth_reg_map.svh
// cfg bus register map, word offsets on cfg_addr_i
// included inside eth_pkg, so it only holds localparams
// offsets not listed here read as zero and ignore writes
`ifndef ETH_REG_MAP_SVH
`define ETH_REG_MAP_SVH

// word offsets
localparam int unsigned REG_CTRL   = 0;  // read/write
localparam int unsigned REG_TX_LEN = 1;  // read/write, low 16 bits
localparam int unsigned REG_STATUS = 2;  // read only
localparam int unsigned REG_RX_LEN = 3;  // read only, last frame length

// REG_CTRL bit positions
localparam int unsigned CTRL_EN_TX     = 0;
localparam int unsigned CTRL_EN_RX     = 1;
localparam int unsigned CTRL_RX_IRQ_EN = 2;

// REG_STATUS, frame count sits in the low bits
localparam int unsigned STAT_TX_BUSY = 8;

`endif

//--- testbench/tb_udma_ethernet.sv
// testbench for udma_ethernet
// stimulus queues the expected bytes and words
// assertions compare the DUT against the queue heads at each handshake
// inputs change on the falling clock edge, random values come from a fixed seed LCG
module tb_udma_ethernet;
    import eth_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int TOTAL_BYTES = 10 + 8 + 7 + 12 + 5;  // all tx and rx frames
    localparam int WATCHDOG    = 20 * TOTAL_BYTES * CLK_PERIOD + 2000;

    typedef struct packed {
        logic      last;
        eth_byte_t data;
    } tx_exp_t;

    logic       sys_clk_i;
    logic       rst_i;
    word_t      cfg_data_i;
    cfg_addr_t  cfg_addr_i;
    logic       cfg_valid_i;
    logic       cfg_rwn_i;
    logic       cfg_ready_o;
    word_t      cfg_data_o;
    word_t      data_tx_i;
    logic       data_tx_valid_i;
    logic       data_tx_ready_o;
    word_t      data_rx_o;
    logic       data_rx_valid_o;
    logic       data_rx_ready_i;
    eth_byte_t  eth_tx_data_o;
    logic       eth_tx_valid_o;
    logic       eth_tx_last_o;
    logic       eth_tx_ready_i;
    eth_byte_t  eth_rx_data_i;
    logic       eth_rx_valid_i;
    logic       eth_rx_last_i;
    logic       eth_rx_ready_o;
    logic       eth_rx_event_o;

    tx_exp_t     tx_exp_q[$];   // bytes still to appear on eth_tx
    word_t       rx_exp_q[$];   // words still to appear on data_rx
    tx_exp_t     tx_head;
    word_t       rx_head;
    logic        tx_pending;
    logic        rx_pending;
    logic        rand_on;
    logic        irq_on;
    logic        tx_blocked;
    logic        rx_blocked;
    logic [31:0] seed;
    int          errors;
    int          ev_cnt;
    int          rx_frames;
    int          tests_run;
    int          tests_failed;

    udma_ethernet i_udma_ethernet (.*);

    initial begin
        sys_clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk_i = ~sys_clk_i;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random numbers and models
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bit chance(input int unsigned pct);
        logic [31:0] r;
        r = lcg_next();
        return (r[31:16] % 100) < pct;
    endfunction

    task automatic load_tx_head();
        tx_pending = (tx_exp_q.size() != 0);
        if (tx_pending) tx_head = tx_exp_q[0];
    endtask

    task automatic load_rx_head();
        rx_pending = (rx_exp_q.size() != 0);
        if (rx_pending) rx_head = rx_exp_q[0];
    endtask

    // random back-pressure on both sinks
    always @(negedge sys_clk_i) begin
        eth_tx_ready_i  = rand_on ? chance(70) : 1'b1;
        data_rx_ready_i = rand_on ? chance(60) : 1'b1;
    end

    // pop the model heads after the assertions have sampled them
    always @(posedge sys_clk_i) begin
        if (!rst_i && eth_tx_valid_o && eth_tx_ready_i && tx_exp_q.size() != 0) begin
            void'(tx_exp_q.pop_front());
            load_tx_head();
        end
        if (!rst_i && data_rx_valid_o && data_rx_ready_i && rx_exp_q.size() != 0) begin
            void'(rx_exp_q.pop_front());
            load_rx_head();
        end
        if (!rst_i && eth_rx_event_o) ev_cnt++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_cfg_ready: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        cfg_ready_o)
        else begin
            errors++;
            $display("FAILED t=%0t cfg_ready_o got %b exp 1", $time, $sampled(cfg_ready_o));
        end

    a_tx_extra: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_tx_valid_o && eth_tx_ready_i |-> tx_pending)
        else begin
            errors++;
            $display("ERROR t=%0t eth_tx sent a byte that was not expected", $time);
        end

    a_tx_data: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_tx_valid_o && eth_tx_ready_i && tx_pending |-> eth_tx_data_o == tx_head.data)
        else begin
            errors++;
            $display("FAILED t=%0t eth_tx_data_o got %h exp %h", $time,
                     $sampled(eth_tx_data_o), $sampled(tx_head.data));
        end

    a_tx_last: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_tx_valid_o && eth_tx_ready_i && tx_pending |-> eth_tx_last_o == tx_head.last)
        else begin
            errors++;
            $display("FAILED t=%0t eth_tx_last_o got %b exp %b", $time,
                     $sampled(eth_tx_last_o), $sampled(tx_head.last));
        end

    a_rx_extra: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        data_rx_valid_o && data_rx_ready_i |-> rx_pending)
        else begin
            errors++;
            $display("ERROR t=%0t data_rx delivered a word that was not expected", $time);
        end

    a_rx_data: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        data_rx_valid_o && data_rx_ready_i && rx_pending |-> data_rx_o == rx_head)
        else begin
            errors++;
            $display("FAILED t=%0t data_rx_o got %h exp %h", $time,
                     $sampled(data_rx_o), $sampled(rx_head));
        end

    a_event_gate: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        eth_rx_event_o |-> irq_on)
        else begin
            errors++;
            $display("ERROR t=%0t rx event fired with rx_irq_en clear", $time);
        end

    a_tx_off: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        tx_blocked |-> !data_tx_ready_o)
        else begin
            errors++;
            $display("ERROR t=%0t uDMA tx ready went high with en_tx clear", $time);
        end

    a_rx_off: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        rx_blocked |-> !eth_rx_ready_o && !data_rx_valid_o)
        else begin
            errors++;
            $display("ERROR t=%0t rx path took a byte or gave a word with en_rx clear", $time);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks start and end on a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic cfg_write(input int unsigned addr, input word_t data);
        cfg_addr_i  = cfg_addr_t'(addr);
        cfg_data_i  = data;
        cfg_rwn_i   = 1'b0;
        cfg_valid_i = 1'b1;
        @(negedge sys_clk_i);
        cfg_valid_i = 1'b0;
    endtask

    task automatic check_reg(input int unsigned addr, input word_t exp, input string name);
        word_t got;
        cfg_addr_i  = cfg_addr_t'(addr);
        cfg_rwn_i   = 1'b1;
        cfg_valid_i = 1'b1;
        @(negedge sys_clk_i);   // read data is out after the request edge
        cfg_valid_i = 1'b0;
        got = cfg_data_o;
        assert (got == exp) else begin
            errors++;
            $display("FAILED t=%0t cfg_data_o (%s) got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic set_ctrl(input logic en_tx, input logic en_rx, input logic irq_en);
        word_t d;
        d = '0;
        d[CTRL_EN_TX]     = en_tx;
        d[CTRL_EN_RX]     = en_rx;
        d[CTRL_RX_IRQ_EN] = irq_en;
        cfg_write(REG_CTRL, d);
        irq_on = irq_en;
    endtask

    task automatic push_word(input word_t w);
        data_tx_i       = w;
        data_tx_valid_i = 1'b1;
        while (!data_tx_ready_o) @(negedge sys_clk_i);
        @(negedge sys_clk_i);   // taken on the edge just passed
        data_tx_valid_i = 1'b0;
    endtask

    task automatic send_tx_frame(input int unsigned len);
        word_t       words[$];
        word_t       w;
        int unsigned k;
        cfg_write(REG_TX_LEN, word_t'(len));
        for (k = 0; k < len; k++) begin
            if (k % BYTES_PER_WORD == 0) begin
                w = lcg_next();
                words.push_back(w);
            end
            tx_exp_q.push_back(tx_exp_t'{last: (k == len - 1),
                data: w[(k % BYTES_PER_WORD) * BYTE_W +: BYTE_W]});
        end
        load_tx_head();
        foreach (words[i]) begin
            push_word(words[i]);
        end
        while (tx_pending) @(negedge sys_clk_i);
    endtask

    task automatic recv_rx_frame(input int unsigned len);
        eth_byte_t   bytes[$];
        word_t       w;
        int unsigned k;
        w = '0;
        for (k = 0; k < len; k++) begin
            bytes.push_back(eth_byte_t'(lcg_next() >> 24));
            w[(k % BYTES_PER_WORD) * BYTE_W +: BYTE_W] = bytes[k];
            if (k % BYTES_PER_WORD == BYTES_PER_WORD - 1 || k == len - 1) begin
                rx_exp_q.push_back(w);   // partial word keeps zero upper bytes
                w = '0;
            end
        end
        load_rx_head();
        for (k = 0; k < len; k++) begin
            while (chance(25)) @(negedge sys_clk_i);   // idle gap
            eth_rx_data_i  = bytes[k];
            eth_rx_last_i  = (k == len - 1);
            eth_rx_valid_i = 1'b1;
            while (!eth_rx_ready_o) @(negedge sys_clk_i);
            @(negedge sys_clk_i);
            eth_rx_valid_i = 1'b0;
            eth_rx_last_i  = 1'b0;
        end
        while (rx_pending) @(negedge sys_clk_i);
        repeat (2) @(negedge sys_clk_i);   // frame_done lands in the registers
        rx_frames++;
    endtask

    task automatic check_rx_status(input int unsigned len, input int exp_events);
        check_reg(REG_RX_LEN, word_t'(len), "REG_RX_LEN");
        check_reg(REG_STATUS, word_t'(rx_frames % 256), "REG_STATUS");
        assert (ev_cnt == exp_events) else begin
            errors++;
            $display("FAILED t=%0t eth_rx_event_o count got %0d exp %0d",
                     $time, ev_cnt, exp_events);
        end
    endtask

    task automatic end_test(input string name, input int e0);
        tests_run++;
        if (errors != e0) begin
            tests_failed++;
            $display("test %-22s bad, %0d errors", name, errors - e0);
        end else begin
            $display("test %-22s ok", name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          e0;
        int unsigned a;
        seed            = 32'h4f21bc90;
        rst_i           = 1'b1;
        cfg_data_i      = '0;
        cfg_addr_i      = '0;
        cfg_valid_i     = 1'b0;
        cfg_rwn_i       = 1'b1;
        data_tx_i       = '0;
        data_tx_valid_i = 1'b0;
        data_rx_ready_i = 1'b1;
        eth_tx_ready_i  = 1'b1;
        eth_rx_data_i   = '0;
        eth_rx_valid_i  = 1'b0;
        eth_rx_last_i   = 1'b0;
        tx_pending      = 1'b0;
        rx_pending      = 1'b0;
        tx_head         = '0;
        rx_head         = '0;
        rand_on         = 1'b0;
        irq_on          = 1'b0;
        tx_blocked      = 1'b0;
        rx_blocked      = 1'b0;
        errors          = 0;
        ev_cnt          = 0;
        rx_frames       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (16) @(posedge sys_clk_i);
        @(negedge sys_clk_i);
        rst_i = 1'b0;

        e0 = errors;
        for (a = 0; a < 2 ** CFG_ADDR_W; a++) begin
            check_reg(a, '0, $sformatf("reset addr %0d", a));
        end
        cfg_write(REG_CTRL, 32'h0000_0007);
        check_reg(REG_CTRL, 32'h0000_0007, "REG_CTRL");
        cfg_write(REG_TX_LEN, 32'hcafe_1234);
        check_reg(REG_TX_LEN, 32'h0000_1234, "REG_TX_LEN");
        cfg_write(REG_STATUS, '1);   // read only
        check_reg(REG_STATUS, '0, "REG_STATUS");
        end_test("register access", e0);

        e0 = errors;
        rand_on = 1'b1;
        set_ctrl(1'b1, 1'b1, 1'b1);
        send_tx_frame(10);   // two bytes of the third word dropped
        send_tx_frame(8);
        end_test("tx serialization", e0);

        e0 = errors;
        recv_rx_frame(7);
        check_rx_status(7, 1);
        recv_rx_frame(12);
        check_rx_status(12, 2);
        end_test("rx packing", e0);

        e0 = errors;
        set_ctrl(1'b1, 1'b1, 1'b0);
        recv_rx_frame(5);
        check_rx_status(5, 2);   // no new event
        end_test("rx status and event", e0);

        e0 = errors;
        set_ctrl(1'b0, 1'b0, 1'b1);
        tx_blocked      = 1'b1;
        rx_blocked      = 1'b1;
        data_tx_i       = lcg_next();
        data_tx_valid_i = 1'b1;
        eth_rx_data_i   = 8'h5a;
        eth_rx_last_i   = 1'b1;
        eth_rx_valid_i  = 1'b1;
        repeat (20) @(negedge sys_clk_i);
        data_tx_valid_i = 1'b0;
        eth_rx_valid_i  = 1'b0;
        eth_rx_last_i   = 1'b0;
        tx_blocked      = 1'b0;
        rx_blocked      = 1'b0;
        check_rx_status(5, 2);
        end_test("enables", e0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
